// File: friscv_pkg.sv
//////////////////////////////
// Shared widths, RV32 field positions and opcode constants
// Imported by every execution-side module of the core
//////////////////////////////

package friscv_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    // Bit offsets of the instruction fields
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int FUNCT7_LSB = 25;

    localparam opcode_t OPCODE_R_ARITH = 7'b0110011;
    localparam opcode_t OPCODE_I_ARITH = 7'b0010011;

    localparam funct7_t FUNCT7_BASE   = 7'b0000000;
    localparam funct7_t FUNCT7_ALT    = 7'b0100000;
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

    // funct3 of the arithmetic group
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_MUL     = 3'b000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

endpackage

// File: friscv_inst_issuer.sv
//////////////////////////////
// Instruction issuer, takes words from outside and
// pushes them into the queue against credits
//////////////////////////////

`timescale 1ns/1ps

module friscv_inst_issuer import friscv_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  aclk,
    input  logic  reset,
    // Outside instruction stream
    input  logic  inst_valid,
    output logic  inst_ready,
    input  inst_t inst_word,
    // Queue side
    output logic  push_valid,
    output inst_t push_word,
    input  logic  credit_return
);

    localparam int CRED_W = $clog2(QUEUE_DEPTH + 1);

    logic [CRED_W-1:0] credits;
    logic              xfer;

    // Only accept while the queue has a free slot reserved
    assign inst_ready = (credits != '0);
    assign xfer       = inst_valid & inst_ready;

    // Spend on accept, regain on each pop, both may hit together
    always_ff @(posedge aclk) begin
        if (reset) begin
            credits    <= CRED_W'(QUEUE_DEPTH);
            push_valid <= 1'b0;
        end else begin
            credits    <= credits + CRED_W'(credit_return) - CRED_W'(xfer);
            push_valid <= xfer;
        end
    end

    always_ff @(posedge aclk) begin
        if (xfer) begin
            push_word <= inst_word;
        end
    end

endmodule

// File: friscv_inst_queue.sv
//////////////////////////////
// Circular instruction FIFO, one credit back per pop
//////////////////////////////

`timescale 1ns/1ps

module friscv_inst_queue import friscv_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic  aclk,
    input  logic  reset,
    // Push side, credit controlled so never full on push
    input  logic  push_valid,
    input  inst_t push_word,
    output logic  credit_return,
    // Pop side
    output logic  proc_valid,
    input  logic  proc_ready,
    output inst_t proc_word
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    inst_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    // Wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign proc_valid    = (count != '0);
    assign proc_word     = mem[rd_ptr];
    assign pop           = proc_valid & proc_ready;
    assign credit_return = pop;

    always_ff @(posedge aclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push_valid) - CNT_W'(pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_word;
        end
    end

endmodule

// File: friscv_alu.sv
//////////////////////////////
// Integer ALU, result registered one cycle after issue
//////////////////////////////

`timescale 1ns/1ps

module friscv_alu import friscv_pkg::*; (
    input  logic      aclk,
    input  logic      reset,
    // Issue side
    input  logic      alu_valid,
    input  alu_op_e   alu_op,
    input  xlen_t     alu_a,
    input  xlen_t     alu_b,
    input  reg_addr_t alu_rd,
    // Result side
    output logic      alu_wr,
    output reg_addr_t alu_rd_addr,
    output xlen_t     alu_result
);

    xlen_t      res;
    logic [4:0] shamt;

    assign shamt = alu_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  res = alu_a + alu_b;
            ALU_SUB:  res = alu_a - alu_b;
            ALU_SLL:  res = alu_a << shamt;
            ALU_SLT:  res = xlen_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU: res = xlen_t'(alu_a < alu_b);
            ALU_XOR:  res = alu_a ^ alu_b;
            ALU_SRL:  res = alu_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  res = xlen_t'($signed(alu_a) >>> shamt);
            ALU_OR:   res = alu_a | alu_b;
            ALU_AND:  res = alu_a & alu_b;
            default:  res = '0;
        endcase
    end

    // Write strobe
    always_ff @(posedge aclk) begin
        if (reset) begin
            alu_wr <= 1'b0;
        end else begin
            alu_wr <= alu_valid;
        end
    end

    // Payload, only loaded on issue
    always_ff @(posedge aclk) begin
        if (alu_valid) begin
            alu_rd_addr <= alu_rd;
            alu_result  <= res;
        end
    end

endmodule

// File: friscv_muldiv.sv
//////////////////////////////
// Shift-add multiplier for MUL, low XLEN bits,
// busy for XLEN cycles after each accept
//////////////////////////////

`timescale 1ns/1ps

module friscv_muldiv import friscv_pkg::*; (
    input  logic      aclk,
    input  logic      reset,
    input  logic      m_valid,
    output logic      m_ready,
    input  xlen_t     m_a,
    input  xlen_t     m_b,
    input  reg_addr_t m_rd,
    output logic      m_wr,
    output reg_addr_t m_rd_addr,
    output xlen_t     m_result
);

    localparam int STEP_W = $clog2(XLEN);

    typedef enum logic {IDLE, BUSY} state_t;

    state_t            state;
    logic [STEP_W-1:0] step;
    xlen_t             mcand;
    xlen_t             mplier;
    xlen_t             acc_next;

    assign m_ready  = (state == IDLE);
    // m_result doubles as the accumulator
    assign acc_next = mplier[0] ? m_result + mcand : m_result;

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
            step  <= '0;
            m_wr  <= 1'b0;
        end else begin
            m_wr <= 1'b0;
            case (state)
                IDLE: begin
                    if (m_valid) begin
                        state <= BUSY;
                        step  <= '0;
                    end
                end
                default: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(XLEN - 1)) begin
                        state <= IDLE;
                        m_wr  <= 1'b1;
                    end
                end
            endcase
        end
    end

    // One multiplier bit per cycle, LSB first
    always_ff @(posedge aclk) begin
        if (state == IDLE && m_valid) begin
            m_result  <= '0;
            mcand     <= m_a;
            mplier    <= m_b;
            m_rd_addr <= m_rd;
        end else if (state == BUSY) begin
            m_result <= acc_next;
            mcand    <= mcand << 1;
            mplier   <= mplier >> 1;
        end
    end

endmodule

// File: friscv_isa_regs.sv
//////////////////////////////
// RV32 integer register file, x0 reads zero
//////////////////////////////

`timescale 1ns/1ps

module friscv_isa_regs import friscv_pkg::*; (
    input  logic      aclk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    output xlen_t     rs1_val,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs2_val,
    input  logic      rd_wr,
    input  reg_addr_t rd_addr,
    input  xlen_t     rd_val
);

    xlen_t regs [32];

    // Write-through so a dependent instruction sees the value being written
    function automatic xlen_t read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (rd_wr && rd_addr == addr) begin
            return rd_val;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_val = read_port(rs1_addr);
        rs2_val = read_port(rs2_addr);
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && rd_addr != '0) begin
            regs[rd_addr] <= rd_val;
        end
    end

endmodule

// File: friscv_processing.sv
//////////////////////////////
// Decode and dispatch to the ALU or the multiplier,
// merges both results onto the register write port
//////////////////////////////

`timescale 1ns/1ps

module friscv_processing import friscv_pkg::*; #(
    parameter int M_EXTENSION = 1
) (
    input  logic      aclk,
    input  logic      reset,
    input  logic      proc_valid,
    output logic      proc_ready,
    input  inst_t     proc_word,
    // Register file
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  xlen_t     rs1_val,
    input  xlen_t     rs2_val,
    output logic      rd_wr,
    output reg_addr_t rd_addr,
    output xlen_t     rd_val,
    // ALU
    output logic      alu_valid,
    output alu_op_e   alu_op,
    output xlen_t     alu_a,
    output xlen_t     alu_b,
    output reg_addr_t alu_rd,
    input  logic      alu_wr,
    input  reg_addr_t alu_rd_addr,
    input  xlen_t     alu_result,
    // Multiplier
    output logic      m_valid,
    input  logic      m_ready,
    output xlen_t     m_a,
    output xlen_t     m_b,
    output reg_addr_t m_rd,
    input  logic      m_wr,
    input  reg_addr_t m_rd_addr,
    input  xlen_t     m_result
);

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    xlen_t   imm;
    logic    r_inst;
    logic    i_inst;
    logic    m_inst;
    logic    alt_op;

    //////////////////////////////
    // Field extraction
    //////////////////////////////

    assign opcode   = proc_word[OPCODE_LSB +: $bits(opcode_t)];
    assign funct3   = proc_word[FUNCT3_LSB +: $bits(funct3_t)];
    assign funct7   = proc_word[FUNCT7_LSB +: $bits(funct7_t)];
    assign rs1_addr = proc_word[RS1_LSB +: $bits(reg_addr_t)];
    assign rs2_addr = proc_word[RS2_LSB +: $bits(reg_addr_t)];
    assign imm      = {{(XLEN - 12){proc_word[31]}}, proc_word[RS2_LSB +: 12]};

    assign r_inst = (opcode == OPCODE_R_ARITH) &&
                    (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT);
    assign i_inst = (opcode == OPCODE_I_ARITH);
    assign m_inst = (M_EXTENSION != 0) && (opcode == OPCODE_R_ARITH) &&
                    (funct7 == FUNCT7_MULDIV) && (funct3 == F3_MUL);
    // Also the imm[11:5] pattern of srai
    assign alt_op = (funct7 == FUNCT7_ALT);

    //////////////////////////////
    // Dispatch
    //////////////////////////////

    // Unsupported words pop with neither unit selected
    assign proc_ready = m_ready;
    assign alu_valid  = proc_valid & m_ready & (r_inst | i_inst);
    assign m_valid    = proc_valid & m_ready & m_inst;

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_op = (r_inst && alt_op) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = alt_op ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        if (r_inst) begin
            alu_b = rs2_val;
        end else if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
            // Shift amount only, drop the funct7 bits of the immediate
            alu_b = {{(XLEN - 5){1'b0}}, imm[4:0]};
        end else begin
            alu_b = imm;
        end
    end

    assign alu_a  = rs1_val;
    assign alu_rd = proc_word[RD_LSB +: $bits(reg_addr_t)];
    assign m_a    = rs1_val;
    assign m_b    = rs2_val;
    assign m_rd   = alu_rd;

    //////////////////////////////
    // Write-back merge
    //////////////////////////////

    assign rd_wr   = (alu_wr && alu_rd_addr != '0) || (m_wr && m_rd_addr != '0);
    assign rd_addr = m_wr ? m_rd_addr : alu_rd_addr;
    assign rd_val  = m_wr ? m_result : alu_result;

endmodule

// File: friscv_core_top.sv
//////////////////////////////
// Integer execution subsystem, instruction in, write-back out
//////////////////////////////

`timescale 1ns/1ps

module friscv_core_top import friscv_pkg::*; #(
    parameter int QUEUE_DEPTH = 4,
    parameter int M_EXTENSION = 1
) (
    input  logic      aclk,
    input  logic      reset,
    input  logic      inst_valid,
    output logic      inst_ready,
    input  inst_t     inst_word,
    // Register write-back, one per retired instruction
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output xlen_t     wb_val
);

    logic      push_valid, credit_return, proc_valid, proc_ready;
    inst_t     push_word, proc_word;
    reg_addr_t rs1_addr, rs2_addr, alu_rd, alu_rd_addr, m_rd, m_rd_addr;
    xlen_t     rs1_val, rs2_val, alu_a, alu_b, alu_result, m_a, m_b, m_result;
    logic      alu_valid, alu_wr, m_valid, m_ready, m_wr;
    alu_op_e   alu_op;

    friscv_inst_issuer #(.QUEUE_DEPTH(QUEUE_DEPTH)) issuer (.*);

    friscv_inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue (.*);

    friscv_processing #(.M_EXTENSION(M_EXTENSION)) processing (
        .*, .rd_wr(wb_valid), .rd_addr(wb_addr), .rd_val(wb_val)
    );

    friscv_alu alu (.*);

    friscv_muldiv muldiv (.*);

    friscv_isa_regs isa_regs (
        .*, .rd_wr(wb_valid), .rd_addr(wb_addr), .rd_val(wb_val)
    );

endmodule

// File: friscv_tb.sv
//////////////////////////////
// Testbench for the execution subsystem, runs an instruction
// table and checks every write-back against a register model
//////////////////////////////

`timescale 1ns/1ps

module friscv_tb import friscv_pkg::*;;

    localparam int      QUEUE_DEPTH = 4;
    localparam int      M_EXTENSION = 1;
    localparam int      SEED        = 32'hb0c7f5e3;
    localparam opcode_t OPCODE_LOAD = 7'b0000011;

    logic      aclk;
    logic      reset;
    logic      inst_valid;
    logic      inst_ready;
    inst_t     inst_word;
    logic      wb_valid;
    reg_addr_t wb_addr;
    xlen_t     wb_val;

    // Instruction table and expected write-backs
    inst_t     tbl_inst [$];
    logic      tbl_wr [$];
    reg_addr_t tbl_rd [$];
    xlen_t     tbl_val [$];
    xlen_t     model_regs [32];

    int   val_errs;
    int   addr_errs;
    int   other_errs;
    int   cycles;
    int   limit;
    int   wb_idx;
    logic stall_seen;

    friscv_core_top #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .M_EXTENSION(M_EXTENSION)
    ) DUT (.*);

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
    end

    //////////////////////////////
    // Encoding and reference model
    //////////////////////////////

    function automatic inst_t encode_r(input funct7_t f7, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input funct3_t f3,
                                       input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPCODE_R_ARITH};
    endfunction

    function automatic inst_t encode_i(input int imm, input reg_addr_t rs1,
                                       input funct3_t f3, input reg_addr_t rd);
        logic [11:0] imm12;
        imm12 = imm[11:0];
        return {imm12, rs1, f3, rd, OPCODE_I_ARITH};
    endfunction

    // RV32I arithmetic and MUL rules, updates the model registers
    function automatic void model_exec(input inst_t w, output logic wr,
                                       output reg_addr_t rd, output xlen_t val);
        opcode_t    op;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      a;
        xlen_t      b;
        logic       known;
        op    = w[6:0];
        rd    = w[11:7];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = model_regs[w[19:15]];
        b     = (op == OPCODE_R_ARITH) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        known = 1'b1;
        val   = '0;
        if (op == OPCODE_R_ARITH && f7 == 7'b0000001) begin
            known = (f3 == 3'b000);
            val   = a * b;
        end else if (op == OPCODE_R_ARITH && f7 != 7'b0000000 && f7 != 7'b0100000) begin
            known = 1'b0;
        end else if (op == OPCODE_R_ARITH || op == OPCODE_I_ARITH) begin
            case (f3)
                3'b000: val = (op == OPCODE_R_ARITH && f7[5]) ? a - b : a + b;
                3'b001: val = a << b[4:0];
                3'b010: val = {31'b0, $signed(a) < $signed(b)};
                3'b011: val = {31'b0, a < b};
                3'b100: val = a ^ b;
                3'b101: begin
                    if (f7[5]) begin
                        val = $signed(a) >>> b[4:0];
                    end else begin
                        val = a >> b[4:0];
                    end
                end
                3'b110: val = a | b;
                default: val = a & b;
            endcase
        end else begin
            known = 1'b0;
        end
        wr = known && (rd != '0);
        if (wr) begin
            model_regs[rd] = val;
        end
    endfunction

    function automatic void add_entry(input inst_t w);
        logic      wr;
        reg_addr_t rd;
        xlen_t     val;
        model_exec(w, wr, rd, val);
        tbl_inst.push_back(w);
        tbl_wr.push_back(wr);
        tbl_rd.push_back(rd);
        tbl_val.push_back(val);
    endfunction

    // Expected write-backs not yet seen
    function automatic int pending_writes();
        int n;
        n = 0;
        for (int i = wb_idx; i < tbl_wr.size(); i++) begin
            n += tbl_wr[i];
        end
        return n;
    endfunction

    function automatic void build_table();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        // Constants from x0, then I-type forms
        add_entry(encode_i(100, 0, F3_ADD_SUB, 1));
        add_entry(encode_i(-7, 0, F3_ADD_SUB, 2));
        add_entry(encode_i(2047, 0, F3_ADD_SUB, 3));
        add_entry(encode_i(-1, 2, F3_XOR, 4));
        add_entry(encode_i(15, 1, F3_OR, 5));
        add_entry(encode_i(240, 2, F3_AND, 6));
        add_entry(encode_i(-3, 2, F3_SLT, 7));
        add_entry(encode_i(-1, 1, F3_SLTU, 8));
        add_entry(encode_i(20, 3, F3_SLL, 9));
        add_entry(encode_i(4, 2, F3_SRL_SRA, 10));
        add_entry(encode_i(12'h401, 2, F3_SRL_SRA, 11));
        // R-type forms
        add_entry(encode_r(FUNCT7_BASE, 2, 1, F3_ADD_SUB, 12));
        add_entry(encode_r(FUNCT7_ALT, 1, 2, F3_ADD_SUB, 13));
        add_entry(encode_r(FUNCT7_BASE, 5, 2, F3_AND, 14));
        add_entry(encode_r(FUNCT7_BASE, 9, 2, F3_OR, 15));
        add_entry(encode_r(FUNCT7_BASE, 3, 2, F3_XOR, 16));
        add_entry(encode_r(FUNCT7_BASE, 1, 2, F3_SLT, 17));
        add_entry(encode_r(FUNCT7_BASE, 1, 2, F3_SLTU, 18));
        add_entry(encode_r(FUNCT7_BASE, 4, 1, F3_SLL, 19));
        add_entry(encode_r(FUNCT7_BASE, 4, 2, F3_SRL_SRA, 20));
        add_entry(encode_r(FUNCT7_ALT, 4, 2, F3_SRL_SRA, 21));
        add_entry(encode_r(FUNCT7_BASE, 3, 1, F3_ADD_SUB, 22));
        add_entry(encode_r(FUNCT7_ALT, 2, 22, F3_ADD_SUB, 23));
        // MUL, then a dependent burst that piles up behind it
        add_entry(encode_r(FUNCT7_MULDIV, 1, 2, F3_MUL, 24));
        add_entry(encode_r(FUNCT7_MULDIV, 9, 9, F3_MUL, 25));
        add_entry(encode_r(FUNCT7_BASE, 1, 25, F3_ADD_SUB, 26));
        add_entry(encode_i(1, 26, F3_ADD_SUB, 27));
        add_entry(encode_r(FUNCT7_BASE, 25, 27, F3_XOR, 28));
        add_entry(encode_r(FUNCT7_ALT, 27, 28, F3_ADD_SUB, 29));
        add_entry(encode_r(FUNCT7_BASE, 2, 29, F3_OR, 30));
        add_entry(encode_r(FUNCT7_BASE, 1, 30, F3_AND, 31));
        add_entry(encode_i(3, 31, F3_ADD_SUB, 1));
        add_entry(encode_r(FUNCT7_BASE, 2, 1, F3_SLTU, 5));
        // x0 targets and unsupported words
        add_entry(encode_i(55, 1, F3_ADD_SUB, 0));
        add_entry(encode_r(FUNCT7_BASE, 0, 0, F3_ADD_SUB, 6));
        add_entry(encode_r(FUNCT7_MULDIV, 2, 1, F3_MUL, 0));
        add_entry({12'h004, 5'd1, 3'b010, 5'd8, OPCODE_LOAD});
        add_entry(encode_r(FUNCT7_MULDIV, 2, 1, 3'b001, 9));
        add_entry(encode_r(FUNCT7_BASE, 3, 0, F3_ADD_SUB, 7));
    endfunction

    //////////////////////////////
    // Drive and check
    //////////////////////////////

    task automatic send_inst(input inst_t w);
        inst_valid = 1'b1;
        inst_word  = w;
        while (!inst_ready) begin
            stall_seen = 1'b1;
            @(posedge aclk);
            #1;
        end
        @(posedge aclk);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic check_xlen(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            val_errs++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t exp,
                                  input reg_addr_t act);
        if (exp !== act) begin
            addr_errs++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // Write-backs retire in program order, silent entries are skipped
    always @(negedge aclk) begin
        if (!reset && wb_valid) begin
            while (wb_idx < tbl_wr.size() && !tbl_wr[wb_idx]) begin
                wb_idx++;
            end
            if (wb_idx >= tbl_wr.size()) begin
                other_errs++;
                $display("Write-back to x%0d at %0t when none was expected", wb_addr, $time);
            end else begin
                check_reg_addr("wb_addr", tbl_rd[wb_idx], wb_addr);
                check_xlen("wb_val", tbl_val[wb_idx], wb_val);
                wb_idx++;
            end
        end
    end

    initial begin
        wait (limit != 0);
        while (cycles < limit) begin
            @(posedge aclk);
        end
        other_errs += pending_writes();
        $display("Timeout after %0d cycles with %0d write-backs missing", cycles,
                 pending_writes());
        $display("Errors: value %0d, address %0d, other %0d", val_errs, addr_errs, other_errs);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int gap;
        void'($urandom(SEED));
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst_word  = '0;
        val_errs   = 0;
        addr_errs  = 0;
        other_errs = 0;
        cycles     = 0;
        wb_idx     = 0;
        stall_seen = 1'b0;
        build_table();
        limit = tbl_inst.size() * (XLEN + 8) + 200;
        repeat (8) @(posedge aclk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < tbl_inst.size(); i++) begin
            gap = $urandom % 4;
            repeat (gap) @(posedge aclk);
            if (gap != 0) begin
                #1;
            end
            send_inst(tbl_inst[i]);
        end
        while (pending_writes() != 0) begin
            @(posedge aclk);
        end
        // Leave room for a stray late write-back
        repeat (XLEN + 8) @(posedge aclk);
        if (!stall_seen) begin
            other_errs++;
            $display("inst_ready never went low during the burst behind the MUL");
        end
        $display("Errors: value %0d, address %0d, other %0d", val_errs, addr_errs, other_errs);
        if (val_errs + addr_errs + other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: all.f
friscv_pkg.sv
friscv_inst_issuer.sv
friscv_inst_queue.sv
friscv_alu.sv
friscv_muldiv.sv
friscv_isa_regs.sv
friscv_processing.sv
friscv_core_top.sv
friscv_tb.sv
